/* src/wfd_pkg.sv */
package wfd_pkg;

  typedef logic [31:0] word_t;       // one word on either stream or in the buffer
  typedef logic [25:0] raw_pair_t;   // {sample b, sample a}, 13 bits each

  localparam int HDR_WORDS = 4;      // header words per event

  // opcode sits in bits 31:24 of a command header word
  typedef enum logic [7:0] {
    OP_REG_WRITE  = 8'h01,
    OP_REG_READ   = 8'h02,
    OP_EVENT_READ = 8'h03
  } opcode_e;

  typedef enum logic [7:0] {
    ST_OK       = 8'h00,
    ST_EMPTY    = 8'h01,           // no event waiting
    ST_BAD_OP   = 8'h02,
    ST_BAD_ADDR = 8'h03
  } status_e;

  typedef enum logic [7:0] {
    REG_BUFFER_SIZE    = 8'h00,
    REG_CHANNEL_NUM    = 8'h01,
    REG_POST_TRIG_SIZE = 8'h02,
    REG_INIT_TRIG_NUM  = 8'h03,
    REG_CUR_TRIG_NUM   = 8'h04     // read only
  } reg_addr_e;

  typedef enum logic [1:0] {IDLE, FILL, POST, HEADER} acq_state_e;

  typedef struct packed {
    opcode_e   opcode;
    reg_addr_e addr;
    word_t     value;              // second word, register write only
  } cmd_t;

  // register block towards the acquisition controller
  typedef struct packed {
    word_t buffer_size;            // words read out per event
    word_t channel_num;
    word_t post_trig_size;         // words written after the trigger
    word_t initial_trig_num;
    logic  trig_num_we;            // one-cycle load of the trigger number
  } acq_cfg_t;

  typedef struct packed {
    word_t data;
    logic  last;                   // final item of a reply
  } rsp_item_t;

endpackage

/* src/sample_buffer.sv */
`timescale 1ns/10ps
module sample_buffer #(
  parameter int BUF_ADDR_W = 12
) (
  input  logic                  clk125,
  input  logic                  wr_en,     // acquisition side
  input  logic [BUF_ADDR_W-1:0] wr_addr,
  input  wfd_pkg::word_t        wr_word,
  input  logic [BUF_ADDR_W-1:0] rd_addr,   // readout side
  output wfd_pkg::word_t        rd_word
);
  import wfd_pkg::*;

  word_t mem [2**BUF_ADDR_W];  // two sign-extended samples per word

  always_ff @(posedge clk125) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_word;
    end
  end

  // read port is registered, data one cycle after the address
  always_ff @(posedge clk125) begin
    rd_word <= mem[rd_addr];
  end

endmodule

/* src/header_fifo.sv */
`timescale 1ns/10ps
module header_fifo #(
  parameter int HDR_DEPTH = 16
) (
  input  logic                           clk125,
  input  logic                           arst_n,
  input  logic                           push,
  input  wfd_pkg::word_t                 push_word,
  input  logic                           pop,
  output wfd_pkg::word_t                 pop_word,
  output logic                           empty,
  output logic [$clog2(HDR_DEPTH+1)-1:0] free_slots
);
  import wfd_pkg::*;

  localparam int PTR_W = $clog2(HDR_DEPTH);
  localparam int CNT_W = $clog2(HDR_DEPTH+1);

  word_t            mem [HDR_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;    // words held
  logic             do_push;
  logic             do_pop;

  assign do_push = push && (count != CNT_W'(HDR_DEPTH));  // full fifo drops the word
  assign do_pop  = pop && (count != '0);

  assign empty      = (count == '0);
  assign free_slots = CNT_W'(HDR_DEPTH) - count;
  assign pop_word   = mem[rd_ptr];  // head word falls through

  always_ff @(posedge clk125) begin
    if (do_push) begin
      mem[wr_ptr] <= push_word;
    end
  end

  always_ff @(posedge clk125 or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(HDR_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(HDR_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

endmodule

/* src/adc_acq_ctrl.sv */
`timescale 1ns/10ps
module adc_acq_ctrl #(
  parameter int BUF_ADDR_W = 12,
  parameter int HDR_DEPTH  = 16
) (
  input  logic                           clk125,
  input  logic                           arst_n,
  input  wfd_pkg::raw_pair_t             adc_raw,
  input  logic                           adc_strobe,
  input  logic                           acq_arm,
  input  logic                           acq_trig,
  output logic                           acq_done,
  input  wfd_pkg::acq_cfg_t              cfg,
  output wfd_pkg::word_t                 cur_trig_num,
  output logic                           buf_wr_en,
  output logic [BUF_ADDR_W-1:0]          buf_wr_addr,
  output wfd_pkg::word_t                 buf_wr_word,
  output logic                           hdr_push,
  output wfd_pkg::word_t                 hdr_word,
  input  logic [$clog2(HDR_DEPTH+1)-1:0] hdr_free
);
  import wfd_pkg::*;

  localparam int IDX_W = $clog2(HDR_WORDS);

  acq_state_e            state;
  logic [BUF_ADDR_W-1:0] wr_ptr;      // next address to write
  logic [BUF_ADDR_W-1:0] last_addr;
  word_t                 post_left;   // post-trigger words still to come
  logic [IDX_W-1:0]      hdr_idx;
  logic                  hdr_end;
  logic                  trig_ok;

  ////////////////////
  // sample packing

  // over-range flag rides in bit 0 of each code, sign bit is bit 12
  assign buf_wr_word = {{3{adc_raw[25]}}, adc_raw[25:13],   // sample b
                        {3{adc_raw[12]}}, adc_raw[12:0]};   // sample a

  assign buf_wr_en   = adc_strobe && (state == FILL || state == POST);
  assign buf_wr_addr = wr_ptr;
  assign last_addr   = wr_ptr - 1'b1;  // pointer has moved past the last word

  // refuse a trigger whose header would not fit
  assign trig_ok = acq_trig && (state == FILL) && (hdr_free >= HDR_WORDS);

  ////////////////////
  // event header
  assign hdr_push = (state == HEADER);
  assign hdr_end  = (hdr_idx == IDX_W'(HDR_WORDS-1));

  always_comb begin
    case (hdr_idx)
      0:       hdr_word = cur_trig_num;
      1:       hdr_word = cfg.channel_num;
      2:       hdr_word = cfg.buffer_size;
      default: hdr_word = word_t'(last_addr);  // readout counts back from here
    endcase
  end

  ////////////////////
  // state machine
  always_ff @(posedge clk125 or negedge arst_n) begin
    if (!arst_n) begin
      state        <= IDLE;
      wr_ptr       <= '0;
      post_left    <= '0;
      hdr_idx      <= '0;
      acq_done     <= 1'b0;
      cur_trig_num <= '0;
    end else begin
      if (buf_wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;  // wraps at the buffer depth
      end
      case (state)
        IDLE: begin
          if (acq_done) begin
            if (!acq_arm) begin
              acq_done <= 1'b0;   // master has seen done
            end
          end else if (acq_arm) begin
            state <= FILL;
          end
        end
        FILL: begin
          if (!acq_arm) begin
            state <= IDLE;
          end else if (trig_ok) begin
            post_left <= cfg.post_trig_size;
            state     <= (cfg.post_trig_size == '0) ? HEADER : POST;
          end
        end
        POST: begin
          if (adc_strobe) begin
            post_left <= post_left - 1'b1;
            if (post_left == word_t'(1)) begin
              state <= HEADER;
            end
          end
        end
        default: begin            // HEADER, one word per cycle
          hdr_idx <= hdr_idx + 1'b1;
          if (hdr_end) begin
            hdr_idx  <= '0;
            acq_done <= 1'b1;
            state    <= IDLE;
          end
        end
      endcase
      // trigger number, a load wins over the count
      if (cfg.trig_num_we) begin
        cur_trig_num <= cfg.initial_trig_num;
      end else if (state == HEADER && hdr_end) begin
        cur_trig_num <= cur_trig_num + 1'b1;
      end
    end
  end

endmodule

/* src/cmd_decode.sv */
`timescale 1ns/10ps
module cmd_decode (
  input  logic           clk125,
  input  logic           arst_n,
  input  wfd_pkg::word_t rx_data,
  input  logic           rx_tvalid,
  input  logic           rx_tlast,
  output logic           rx_tready,
  output wfd_pkg::cmd_t  cmd,
  output logic           cmd_valid,
  input  logic           cmd_take
);
  import wfd_pkg::*;

  logic [1:0] word_idx;    // 0 header, 1 value, 2 ignored tail
  logic       rx_fire;
  logic       valid_next;

  assign rx_fire    = rx_tvalid && rx_tready;
  assign valid_next = cmd_take ? 1'b0 : (cmd_valid || (rx_fire && rx_tlast));

  // command words
  always_ff @(posedge clk125) begin
    if (rx_fire) begin
      case (word_idx)
        2'd0: begin
          cmd.opcode <= opcode_e'(rx_data[31:24]);  // unknown codes kept for the executor
          cmd.addr   <= reg_addr_e'(rx_data[7:0]);
          cmd.value  <= '0;
        end
        2'd1: cmd.value <= rx_data;
        default: cmd.value <= cmd.value;  // words past the value are dropped
      endcase
    end
  end

  always_ff @(posedge clk125 or negedge arst_n) begin
    if (!arst_n) begin
      word_idx  <= '0;
      cmd_valid <= 1'b0;
      rx_tready <= 1'b0;
    end else begin
      cmd_valid <= valid_next;
      rx_tready <= !valid_next;   // closed while a command waits
      if (rx_fire) begin
        if (rx_tlast) begin
          word_idx <= '0;
        end else if (word_idx != 2'd2) begin
          word_idx <= word_idx + 1'b1;
        end
      end
    end
  end

endmodule

/* src/cmd_execute.sv */
`timescale 1ns/10ps
module cmd_execute #(
  parameter int BUF_ADDR_W = 12
) (
  input  logic                  clk125,
  input  logic                  arst_n,
  input  wfd_pkg::cmd_t         cmd,
  input  logic                  cmd_valid,
  output logic                  cmd_take,
  output wfd_pkg::acq_cfg_t     cfg,
  input  wfd_pkg::word_t        cur_trig_num,
  output logic                  hdr_pop,
  input  wfd_pkg::word_t        hdr_word,
  input  logic                  hdr_empty,
  output logic [BUF_ADDR_W-1:0] buf_rd_addr,
  input  wfd_pkg::word_t        buf_rd_word,
  output wfd_pkg::rsp_item_t    item,
  output logic                  item_valid,
  input  logic                  item_ready
);
  import wfd_pkg::*;

  typedef enum logic [2:0] {X_IDLE, X_STATUS, X_VALUE, X_HDR, X_DATA} exec_state_e;

  localparam int IDX_W = $clog2(HDR_WORDS);

  exec_state_e           state;
  opcode_e               op_q;
  status_e               status_q;
  status_e               status_d;
  word_t                 value_q;       // register read result
  word_t                 reg_rd;
  word_t                 data_cnt;      // data words sent
  logic [IDX_W-1:0]      hdr_idx;
  logic [BUF_ADDR_W-1:0] rd_ptr;
  logic [BUF_ADDR_W-1:0] rd_ptr_next;
  logic                  item_fire;
  logic                  hdr_last;
  logic                  data_last;
  logic                  status_last;

  assign cmd_take    = (state == X_IDLE) && cmd_valid;
  assign item_valid  = (state != X_IDLE);
  assign item_fire   = item_valid && item_ready;
  assign hdr_pop     = (state == X_HDR) && item_fire;
  assign hdr_last    = (hdr_idx == IDX_W'(HDR_WORDS-1));
  assign data_last   = (data_cnt == cfg.buffer_size - 1'b1);
  assign status_last = (status_q != ST_OK) || (op_q == OP_REG_WRITE);

  ////////////////////
  // decode
  always_comb begin
    reg_rd   = '0;
    status_d = ST_OK;
    case (cmd.addr)
      REG_BUFFER_SIZE:    reg_rd = cfg.buffer_size;
      REG_CHANNEL_NUM:    reg_rd = cfg.channel_num;
      REG_POST_TRIG_SIZE: reg_rd = cfg.post_trig_size;
      REG_INIT_TRIG_NUM:  reg_rd = cfg.initial_trig_num;
      REG_CUR_TRIG_NUM:   reg_rd = cur_trig_num;
      default:            status_d = ST_BAD_ADDR;
    endcase
    if (cmd.opcode == OP_EVENT_READ) begin
      status_d = hdr_empty ? ST_EMPTY : ST_OK;
    end else if (cmd.opcode != OP_REG_WRITE && cmd.opcode != OP_REG_READ) begin
      status_d = ST_BAD_OP;
    end else if (cmd.opcode == OP_REG_WRITE && cmd.addr == REG_CUR_TRIG_NUM) begin
      status_d = ST_BAD_ADDR;     // trigger number is read only
    end
  end

  // read address runs one step ahead, so buf_rd_word always holds mem[rd_ptr]
  always_comb begin
    rd_ptr_next = rd_ptr;
    if (hdr_pop && hdr_last) begin
      // oldest word = last address - buffer_size + 1, wrapped
      rd_ptr_next = hdr_word[BUF_ADDR_W-1:0] - cfg.buffer_size[BUF_ADDR_W-1:0] + 1'b1;
    end else if (state == X_DATA && item_fire) begin
      rd_ptr_next = rd_ptr + 1'b1;
    end
  end
  assign buf_rd_addr = rd_ptr_next;

  always_comb begin
    case (state)
      X_STATUS: item = '{data: {op_q, 16'h0000, status_q}, last: status_last};
      X_VALUE:  item = '{data: value_q, last: 1'b1};
      X_HDR:    item = '{data: hdr_word, last: hdr_last && (cfg.buffer_size == '0)};
      default:  item = '{data: buf_rd_word, last: data_last};
    endcase
  end

  always_ff @(posedge clk125) begin
    if (cmd_take) begin
      op_q     <= cmd.opcode;
      status_q <= status_d;
      value_q  <= reg_rd;
    end
  end

  ////////////////////
  // register file and sequencing
  always_ff @(posedge clk125 or negedge arst_n) begin
    if (!arst_n) begin
      state    <= X_IDLE;
      cfg      <= '0;
      hdr_idx  <= '0;
      data_cnt <= '0;
      rd_ptr   <= '0;
    end else begin
      cfg.trig_num_we <= 1'b0;
      rd_ptr          <= rd_ptr_next;
      case (state)
        X_IDLE: begin
          if (cmd_take) begin
            state <= X_STATUS;
            if (cmd.opcode == OP_REG_WRITE && status_d == ST_OK) begin
              case (cmd.addr)
                REG_BUFFER_SIZE:    cfg.buffer_size    <= cmd.value;
                REG_CHANNEL_NUM:    cfg.channel_num    <= cmd.value;
                REG_POST_TRIG_SIZE: cfg.post_trig_size <= cmd.value;
                default: begin    // REG_INIT_TRIG_NUM, the only one left
                  cfg.initial_trig_num <= cmd.value;
                  cfg.trig_num_we      <= 1'b1;
                end
              endcase
            end
          end
        end
        X_STATUS: begin
          if (item_fire) begin
            if (status_last) begin
              state <= X_IDLE;
            end else if (op_q == OP_REG_READ) begin
              state <= X_VALUE;
            end else begin
              state <= X_HDR;
            end
          end
        end
        X_VALUE: begin
          if (item_fire) begin
            state <= X_IDLE;
          end
        end
        X_HDR: begin
          if (item_fire) begin
            hdr_idx  <= hdr_idx + 1'b1;
            data_cnt <= '0;
            if (hdr_last) begin
              hdr_idx <= '0;
              state   <= (cfg.buffer_size == '0) ? X_IDLE : X_DATA;
            end
          end
        end
        default: begin            // X_DATA
          if (item_fire) begin
            data_cnt <= data_cnt + 1'b1;
            if (data_last) begin
              state <= X_IDLE;
            end
          end
        end
      endcase
    end
  end

endmodule

/* src/reply_format.sv */
`timescale 1ns/10ps
module reply_format (
  input  logic               clk125,
  input  logic               arst_n,
  input  wfd_pkg::rsp_item_t item,
  input  logic               item_valid,
  output logic               item_ready,
  output wfd_pkg::word_t     tx_data,
  output logic               tx_tvalid,
  output logic               tx_tlast,
  input  logic               tx_tready
);
  import wfd_pkg::*;

  rsp_item_t  slot [2];   // two-entry ring
  logic       wr_sel;
  logic       rd_sel;
  logic [1:0] count;
  logic       push;
  logic       pop;

  assign item_ready = (count != 2'd2);
  assign push       = item_valid && item_ready;
  assign pop        = tx_tvalid && tx_tready;

  // head entry stays put while the link stalls
  assign tx_tvalid = (count != 2'd0);
  assign tx_data   = slot[rd_sel].data;
  assign tx_tlast  = slot[rd_sel].last;

  always_ff @(posedge clk125) begin
    if (push) begin
      slot[wr_sel] <= item;
    end
  end

  always_ff @(posedge clk125 or negedge arst_n) begin
    if (!arst_n) begin
      wr_sel <= 1'b0;
      rd_sel <= 1'b0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_sel <= !wr_sel;
      end
      if (pop) begin
        rd_sel <= !rd_sel;
      end
      count <= count + 2'(push) - 2'(pop);  // push and pop together keep full rate
    end
  end

endmodule

/* src/channel_top.sv */
`timescale 1ns/10ps
module channel_top #(
  parameter int BUF_ADDR_W = 12,   // 4096 sample words
  parameter int HDR_DEPTH  = 16
) (
  input  logic               clk125,
  input  logic               arst_n,
  input  wfd_pkg::raw_pair_t adc_raw,
  input  logic               adc_strobe,
  input  logic               acq_arm,
  input  logic               acq_trig,
  output logic               acq_done,
  input  wfd_pkg::word_t     rx_data,
  input  logic               rx_tvalid,
  input  logic               rx_tlast,
  output logic               rx_tready,
  output wfd_pkg::word_t     tx_data,
  output logic               tx_tvalid,
  output logic               tx_tlast,
  input  logic               tx_tready
);
  import wfd_pkg::*;

  localparam int FREE_W = $clog2(HDR_DEPTH+1);

  logic                  buf_wr_en;
  logic [BUF_ADDR_W-1:0] buf_wr_addr;
  logic [BUF_ADDR_W-1:0] buf_rd_addr;
  word_t                 buf_wr_word;
  word_t                 buf_rd_word;
  logic                  hdr_push;
  logic                  hdr_pop;
  logic                  hdr_empty;
  word_t                 hdr_push_word;
  word_t                 hdr_pop_word;
  logic [FREE_W-1:0]     hdr_free;
  acq_cfg_t              acq_cfg;        // register block to the controller
  word_t                 cur_trig_num;
  cmd_t                  cmd;
  logic                  cmd_valid;
  logic                  cmd_take;
  rsp_item_t             item;
  logic                  item_valid;
  logic                  item_ready;

  ////////////////////
  // acquisition side
  sample_buffer #(.BUF_ADDR_W(BUF_ADDR_W)) u_sample_buffer (
    .clk125  (clk125),
    .wr_en   (buf_wr_en),
    .wr_addr (buf_wr_addr),
    .wr_word (buf_wr_word),
    .rd_addr (buf_rd_addr),
    .rd_word (buf_rd_word)
  );

  header_fifo #(.HDR_DEPTH(HDR_DEPTH)) u_header_fifo (
    .clk125     (clk125),
    .arst_n     (arst_n),
    .push       (hdr_push),
    .push_word  (hdr_push_word),
    .pop        (hdr_pop),
    .pop_word   (hdr_pop_word),
    .empty      (hdr_empty),
    .free_slots (hdr_free)
  );

  adc_acq_ctrl #(.BUF_ADDR_W(BUF_ADDR_W), .HDR_DEPTH(HDR_DEPTH)) u_adc_acq_ctrl (
    .clk125       (clk125),
    .arst_n       (arst_n),
    .adc_raw      (adc_raw),
    .adc_strobe   (adc_strobe),
    .acq_arm      (acq_arm),
    .acq_trig     (acq_trig),
    .acq_done     (acq_done),
    .cfg          (acq_cfg),
    .cur_trig_num (cur_trig_num),
    .buf_wr_en    (buf_wr_en),
    .buf_wr_addr  (buf_wr_addr),
    .buf_wr_word  (buf_wr_word),
    .hdr_push     (hdr_push),
    .hdr_word     (hdr_push_word),
    .hdr_free     (hdr_free)
  );

  ////////////////////
  // command side
  cmd_decode u_cmd_decode (
    .clk125    (clk125),
    .arst_n    (arst_n),
    .rx_data   (rx_data),
    .rx_tvalid (rx_tvalid),
    .rx_tlast  (rx_tlast),
    .rx_tready (rx_tready),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_take  (cmd_take)
  );

  cmd_execute #(.BUF_ADDR_W(BUF_ADDR_W)) u_cmd_execute (
    .clk125       (clk125),
    .arst_n       (arst_n),
    .cmd          (cmd),
    .cmd_valid    (cmd_valid),
    .cmd_take     (cmd_take),
    .cfg          (acq_cfg),
    .cur_trig_num (cur_trig_num),
    .hdr_pop      (hdr_pop),
    .hdr_word     (hdr_pop_word),
    .hdr_empty    (hdr_empty),
    .buf_rd_addr  (buf_rd_addr),
    .buf_rd_word  (buf_rd_word),
    .item         (item),
    .item_valid   (item_valid),
    .item_ready   (item_ready)
  );

  reply_format u_reply_format (
    .clk125     (clk125),
    .arst_n     (arst_n),
    .item       (item),
    .item_valid (item_valid),
    .item_ready (item_ready),
    .tx_data    (tx_data),
    .tx_tvalid  (tx_tvalid),
    .tx_tlast   (tx_tlast),
    .tx_tready  (tx_tready)
  );

endmodule

/* tests/channel_tb_tasks.svh */
////////////////////
// stream helpers

// called right after a clock edge and returns on the edge that moves the word
task automatic send_word(input word_t w, input logic last);
  rx_data   <= w;
  rx_tvalid <= 1'b1;
  rx_tlast  <= last;
  @(posedge clk125);
  while (!rx_tready) begin
    @(posedge clk125);
  end
endtask

task automatic send_cmd(input logic [7:0] op, input logic [7:0] addr, input word_t value,
                        input bit with_value);
  send_word({op, 16'h0000, addr}, !with_value);  // header word
  if (with_value) begin
    send_word(value, 1'b1);
  end
  rx_tvalid <= 1'b0;
  rx_tlast  <= 1'b0;
  @(posedge clk125);
  // decoder stays closed while the command waits
  check_value("rx_tready after tlast", 32'd0, {31'd0, rx_tready});
endtask

// takes words up to tlast and checks that a stalled word is held
task automatic collect_reply(input bit stall);
  bit    done;
  bit    held;
  word_t held_data;
  logic  held_last;
  done = 1'b0;
  held = 1'b0;
  got_q.delete();
  tx_tready <= 1'b1;
  while (!done) begin
    @(posedge clk125);
    if (held) begin
      check_value("held tvalid", 32'd1, {31'd0, tx_tvalid});
      check_value("held tdata", held_data, tx_data);
      check_value("held tlast", {31'd0, held_last}, {31'd0, tx_tlast});
    end
    held      = tx_tvalid && !tx_tready;
    held_data = tx_data;
    held_last = tx_tlast;
    if (tx_tvalid && tx_tready) begin
      got_q.push_back(tx_data);
      done = tx_tlast;
    end
    if (done) begin
      tx_tready <= 1'b0;
    end else if (stall) begin
      tx_tready <= ($urandom & 1) != 0;
    end else begin
      tx_tready <= 1'b1;
    end
  end
endtask

task automatic compare_reply();
  int i;
  check_value("reply length", exp_q.size(), got_q.size());
  for (i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
    check_value($sformatf("reply word %0d", i), exp_q[i], got_q[i]);
  end
  exp_q.delete();
  got_q.delete();
endtask

function automatic word_t status_word(input logic [7:0] op, input logic [7:0] st);
  return {op, 16'h0000, st};
endfunction

////////////////////
// commands and acquisition
task automatic write_reg(input logic [7:0] addr, input word_t value, input status_e st);
  exp_q.push_back(status_word(OP_REG_WRITE, st));
  send_cmd(OP_REG_WRITE, addr, value, 1'b1);
  collect_reply(1'b0);
  compare_reply();
endtask

task automatic read_reg(input logic [7:0] addr, input word_t value);
  exp_q.push_back(status_word(OP_REG_READ, ST_OK));
  exp_q.push_back(value);
  send_cmd(OP_REG_READ, addr, '0, 1'b0);
  collect_reply(1'b0);
  compare_reply();
endtask

task automatic acquire_event(input int fill_n, input int post_n);
  int wait_cnt;
  @(posedge clk125);
  acq_arm <= 1'b1;
  @(posedge clk125);          // controller moves to FILL
  strobe_pairs(fill_n);
  acq_trig <= 1'b1;
  @(posedge clk125);
  acq_trig <= 1'b0;
  strobe_pairs(post_n);       // returns on the edge of the last write
  wait_cnt = 0;
  while (!acq_done) begin
    @(posedge clk125);
    wait_cnt++;
  end
  check_value("done latency", HDR_WORDS + 1, wait_cnt);
  hdr_model.push_back(exp_trig);
  hdr_model.push_back(cfg_chan);
  hdr_model.push_back(cfg_bs);
  hdr_model.push_back((model_ptr + BUF_DEPTH - 1) % BUF_DEPTH);  // last word written
  exp_trig++;
  acq_arm <= 1'b0;
  while (acq_done) begin
    @(posedge clk125);
  end
endtask

// oldest of the buffer_size words ending at the header's last address comes first
task automatic read_event_check(input bit stall);
  word_t last_addr;
  int    i;
  exp_q.push_back(status_word(OP_EVENT_READ, ST_OK));
  last_addr = hdr_model[HDR_WORDS-1];
  for (i = 0; i < HDR_WORDS; i++) begin
    exp_q.push_back(hdr_model.pop_front());
  end
  for (i = 0; i < cfg_bs; i++) begin
    exp_q.push_back(model_mem[(last_addr + 1 + i - cfg_bs) % BUF_DEPTH]);
  end
  send_cmd(OP_EVENT_READ, 8'h00, '0, 1'b0);
  collect_reply(stall);
  compare_reply();
endtask

task automatic start_test(input string name);
  cur_test = name;
  err_base = err_count;
  tests_run++;
endtask

task automatic end_test();
  if (err_count == err_base) begin
    $display("test %s: ok", cur_test);
  end else begin
    $display("test %s: %0d errors", cur_test, err_count - err_base);
    tests_failed++;
  end
endtask

////////////////////
// directed tests
task automatic registers_rw();
  start_test("registers");
  write_reg(REG_BUFFER_SIZE, 32'h0000_0030, ST_OK);
  read_reg(REG_BUFFER_SIZE, 32'h0000_0030);
  write_reg(REG_CHANNEL_NUM, 32'h0000_0007, ST_OK);
  read_reg(REG_CHANNEL_NUM, 32'h0000_0007);
  write_reg(REG_POST_TRIG_SIZE, 32'h1234_5678, ST_OK);
  read_reg(REG_POST_TRIG_SIZE, 32'h1234_5678);
  write_reg(REG_INIT_TRIG_NUM, 32'h0001_2345, ST_OK);
  read_reg(REG_INIT_TRIG_NUM, 32'h0001_2345);
  read_reg(REG_CUR_TRIG_NUM, 32'h0001_2345);     // loaded by the write
  write_reg(REG_CUR_TRIG_NUM, 32'h0000_0055, ST_BAD_ADDR);
  read_reg(REG_CUR_TRIG_NUM, 32'h0001_2345);     // unchanged
  write_reg(8'h20, 32'hFFFF_FFFF, ST_BAD_ADDR);  // no such register
  read_reg(REG_BUFFER_SIZE, 32'h0000_0030);
  exp_q.push_back(status_word(8'h7E, ST_BAD_OP));
  send_cmd(8'h7E, 8'h00, '0, 1'b0);
  collect_reply(1'b0);
  compare_reply();
  end_test();
endtask

task automatic event_sign_ext();
  start_test("event");
  write_reg(REG_BUFFER_SIZE, 32'd48, ST_OK);
  cfg_bs = 32'd48;
  write_reg(REG_CHANNEL_NUM, 32'd5, ST_OK);
  cfg_chan = 32'd5;
  write_reg(REG_POST_TRIG_SIZE, POST_SIZE, ST_OK);
  write_reg(REG_INIT_TRIG_NUM, 32'd100, ST_OK);
  exp_trig = 32'd100;
  acquire_event(FILL_PAIRS, POST_SIZE);
  read_event_check(1'b0);
  read_reg(REG_CUR_TRIG_NUM, 32'd101);
  end_test();
endtask

task automatic empty_readout();
  start_test("empty");
  exp_q.push_back(status_word(OP_EVENT_READ, ST_EMPTY));
  send_cmd(OP_EVENT_READ, 8'h00, '0, 1'b0);
  collect_reply(1'b0);
  compare_reply();
  end_test();
endtask

// later fills overwrite older event data and the model follows them
task automatic several_events();
  int n;
  start_test("several events");
  for (n = 0; n < 3; n++) begin
    acquire_event(20 + 7*n, POST_SIZE);
  end
  for (n = 0; n < 3; n++) begin
    read_event_check(1'b0);
  end
  end_test();
endtask

task automatic back_pressure_readout();
  start_test("back-pressure");
  write_reg(REG_BUFFER_SIZE, BUF_DEPTH, ST_OK);  // whole buffer
  cfg_bs = BUF_DEPTH;
  acquire_event(30, POST_SIZE);
  read_event_check(1'b1);
  end_test();
endtask

/* tests/channel_tb.sv */
`timescale 1ns/10ps
module channel_tb;
  import wfd_pkg::*;

  localparam int BUF_ADDR_W = 6;
  localparam int BUF_DEPTH  = 2**BUF_ADDR_W;   // 64 words
  localparam int HDR_DEPTH  = 16;
  localparam int FILL_PAIRS = 80;              // wraps the buffer once
  localparam int POST_SIZE  = 10;
  localparam int NUM_EVENTS = 5;               // acquisitions over all tests
  localparam int SEED       = 32'h6af4a3a3;

  // each event takes its fill and post strobes and a readout of up to 5+64 words
  // that may run at half rate under back-pressure. about 40 register commands on top
  localparam int EVENT_CYCLES = FILL_PAIRS + POST_SIZE + 4*BUF_DEPTH + 40;
  localparam int MAX_CYCLES   = 4 * (NUM_EVENTS*EVENT_CYCLES + 40*20);

  logic      clk125;
  logic      arst_n;
  raw_pair_t adc_raw;
  logic      adc_strobe;
  logic      acq_arm;
  logic      acq_trig;
  logic      acq_done;
  word_t     rx_data;
  logic      rx_tvalid;
  logic      rx_tlast;
  logic      rx_tready;
  word_t     tx_data;
  logic      tx_tvalid;
  logic      tx_tlast;
  logic      tx_tready;

  int        cycle_cnt = 0;
  int        err_count = 0;
  int        err_base;          // errors before the running test
  int        tests_run = 0;
  int        tests_failed = 0;
  string     cur_test;

  ////////////////////
  // reference model
  word_t     model_mem [BUF_DEPTH];   // mirror of the sample buffer
  int        model_ptr = 0;           // next write address
  word_t     hdr_model [$];           // expected header words in push order
  word_t     exp_q [$];
  word_t     got_q [$];
  word_t     cfg_bs;                  // buffer_size as last written
  word_t     cfg_chan;
  word_t     exp_trig;                // next trigger number

  channel_top #(.BUF_ADDR_W(BUF_ADDR_W), .HDR_DEPTH(HDR_DEPTH)) UUT (
    .clk125     (clk125),
    .arst_n     (arst_n),
    .adc_raw    (adc_raw),
    .adc_strobe (adc_strobe),
    .acq_arm    (acq_arm),
    .acq_trig   (acq_trig),
    .acq_done   (acq_done),
    .rx_data    (rx_data),
    .rx_tvalid  (rx_tvalid),
    .rx_tlast   (rx_tlast),
    .rx_tready  (rx_tready),
    .tx_data    (tx_data),
    .tx_tvalid  (tx_tvalid),
    .tx_tlast   (tx_tlast),
    .tx_tready  (tx_tready)
  );

  initial begin
    clk125 = 1'b0;
    forever #5 clk125 = ~clk125;   // 10 ns period
  end

  // run limit
  always @(posedge clk125) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES) begin
      $display("timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  task automatic check_value(input string what, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("mismatch in %s, %s: expected %h, actual %h", cur_test, what, exp, act);
      err_count++;
    end
  endtask

  // each 13-bit code widened as a signed number with b in the high half
  function automatic word_t extend_pair(input raw_pair_t raw);
    logic signed [12:0] code_a;
    logic signed [12:0] code_b;
    logic signed [15:0] ext_a;
    logic signed [15:0] ext_b;
    code_a = raw[12:0];
    code_b = raw[25:13];
    ext_a  = code_a;
    ext_b  = code_b;
    return {ext_b, ext_a};
  endfunction

  // one pair per cycle and recorded in the model as it is driven
  task automatic strobe_pairs(input int n);
    logic [31:0] rnd;
    raw_pair_t   raw;
    int          i;
    for (i = 0; i < n; i++) begin
      @(posedge clk125);
      rnd = $urandom;
      raw = rnd[25:0];
      if (i % 7 == 3) begin
        raw = {13'h1001, 13'h1FFF};  // negative with over-range and -1
      end else if (i % 11 == 5) begin
        raw = {13'h0FFF, 13'h1000};  // full scale of both signs
      end
      adc_raw    <= raw;
      adc_strobe <= 1'b1;
      model_mem[model_ptr] = extend_pair(raw);
      model_ptr = (model_ptr + 1) % BUF_DEPTH;
    end
    @(posedge clk125);
    adc_strobe <= 1'b0;
  endtask

  `include "channel_tb_tasks.svh"

  initial begin
    void'($urandom(SEED));
    arst_n     <= 1'b0;
    adc_raw    <= '0;
    adc_strobe <= 1'b0;
    acq_arm    <= 1'b0;
    acq_trig   <= 1'b0;
    rx_data    <= '0;
    rx_tvalid  <= 1'b0;
    rx_tlast   <= 1'b0;
    tx_tready  <= 1'b0;   // replies are only taken inside collect_reply
    repeat (5) @(posedge clk125);
    arst_n <= 1'b1;
    @(posedge clk125);

    registers_rw();
    event_sign_ext();
    empty_readout();
    several_events();
    back_pressure_readout();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+tests
src/wfd_pkg.sv
src/sample_buffer.sv
src/header_fifo.sv
src/adc_acq_ctrl.sv
src/cmd_decode.sv
src/cmd_execute.sv
src/reply_format.sv
src/channel_top.sv
tests/channel_tb.sv

/* Bender.yml */
package:
  name: wfd_channel

sources:
  - src/wfd_pkg.sv
  - src/sample_buffer.sv
  - src/header_fifo.sv
  - src/adc_acq_ctrl.sv
  - src/cmd_decode.sv
  - src/cmd_execute.sv
  - src/reply_format.sv
  - src/channel_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/channel_tb.sv
